/* verilog/uart_settings.svh */
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Width of one data byte
`define UART_DATA_BITS 8

// Ticks per bit cell
`define UART_OVERSAMPLE 16

// One stop bit, counted in ticks
`define UART_STOP_TICKS 16

// Clock cycles per tick, 64 clocks per bit cell
`define UART_TICK_DIVISOR 4

// Receive FIFO holds 4 bytes
`define UART_FIFO_DEPTH_LOG2 2

`endif

/* verilog/uart_pkg.sv */
`default_nettype none

`include "uart_settings.svh"

package uart_pkg;

    // Receiver FSM states
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,
        RX_START = 2'd1, // Waiting for mid of start bit
        RX_DATA  = 2'd2,
        RX_STOP  = 2'd3
    } rx_state_e;

    // Transmitter FSM states
    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_DATA  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_e;

    // Received byte with its strobe or level
    typedef struct packed {
        logic                       valid;
        logic [`UART_DATA_BITS-1:0] data;
    } uart_byte_t;

endpackage

`default_nettype wire

/* verilog/baud_tick_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module baud_tick_gen #(
    parameter int DIVISOR = `UART_TICK_DIVISOR
) (
    input  logic i_clk,
    input  logic i_reset,
    output logic o_tick
);

    // Keep at least one bit even for a divide by one
    localparam int CNT_W = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            cnt    <= '0;
            o_tick <= 1'b0;
        end else if (cnt == CNT_W'(DIVISOR - 1)) begin
            cnt    <= '0;
            o_tick <= 1'b1; // One clock wide
        end else begin
            cnt    <= cnt + 1'b1;
            o_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/uart_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uart_receiver (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  logic                 i_rx,
    input  logic                 i_tick,
    output uart_pkg::uart_byte_t o_byte,
    output logic                 o_frame_err
);

    localparam int TICK_MAX = (`UART_STOP_TICKS > `UART_OVERSAMPLE) ?
                              `UART_STOP_TICKS : `UART_OVERSAMPLE;
    localparam int TICK_W   = $clog2(TICK_MAX);
    localparam int BIT_W    = $clog2(`UART_DATA_BITS);
    localparam int MID_TICK = `UART_OVERSAMPLE / 2 - 1;

    uart_pkg::rx_state_e state, next_state;

    logic [TICK_W-1:0]          tick_cnt, next_tick_cnt;
    logic [BIT_W-1:0]           bit_cnt, next_bit_cnt;
    logic [`UART_DATA_BITS-1:0] data_reg, next_data_reg; // Shift register, LSB arrives first

    // Control state
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= uart_pkg::RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            state    <= next_state;
            tick_cnt <= next_tick_cnt;
            bit_cnt  <= next_bit_cnt;
        end
    end

    always_ff @(posedge i_clk) begin
        data_reg <= next_data_reg;
    end

    always_comb begin
        next_state    = state;
        next_tick_cnt = tick_cnt;
        next_bit_cnt  = bit_cnt;
        next_data_reg = data_reg;
        o_byte.valid  = 1'b0;
        o_byte.data   = data_reg;
        o_frame_err   = 1'b0;

        case (state)
            uart_pkg::RX_IDLE: begin
                if (!i_rx) begin // Falling edge of start bit
                    next_state    = uart_pkg::RX_START;
                    next_tick_cnt = '0;
                end
            end

            uart_pkg::RX_START: begin
                if (i_tick) begin
                    if (tick_cnt == TICK_W'(MID_TICK)) begin
                        next_tick_cnt = '0;
                        next_bit_cnt  = '0;
                        // A high line here was only a glitch
                        next_state = i_rx ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end

            uart_pkg::RX_DATA: begin
                if (i_tick) begin
                    if (tick_cnt == TICK_W'(`UART_OVERSAMPLE - 1)) begin // Mid of bit cell
                        next_tick_cnt = '0;
                        next_data_reg = {i_rx, data_reg[`UART_DATA_BITS-1:1]};
                        if (bit_cnt == BIT_W'(`UART_DATA_BITS - 1)) begin
                            next_state = uart_pkg::RX_STOP;
                        end else begin
                            next_bit_cnt = bit_cnt + 1'b1;
                        end
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end

            uart_pkg::RX_STOP: begin
                if (i_tick) begin
                    if (tick_cnt == TICK_W'(`UART_STOP_TICKS - 1)) begin
                        next_state    = uart_pkg::RX_IDLE;
                        next_tick_cnt = '0;
                        // Stop bit must be high
                        if (i_rx) begin
                            o_byte.valid = 1'b1;
                        end else begin
                            o_frame_err = 1'b1;
                        end
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/uart_transmitter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uart_transmitter (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_tick,
    input  logic                       i_tx_start,
    input  logic [`UART_DATA_BITS-1:0] i_tx_data,
    output logic                       o_tx,
    output logic                       o_tx_busy
);

    localparam int TICK_MAX = (`UART_STOP_TICKS > `UART_OVERSAMPLE) ?
                              `UART_STOP_TICKS : `UART_OVERSAMPLE;
    localparam int TICK_W   = $clog2(TICK_MAX);
    localparam int BIT_W    = $clog2(`UART_DATA_BITS);

    uart_pkg::tx_state_e state, next_state;

    logic [TICK_W-1:0]          tick_cnt, next_tick_cnt;
    logic [BIT_W-1:0]           bit_cnt, next_bit_cnt;
    logic [`UART_DATA_BITS-1:0] shift_reg, next_shift;
    logic                       tx_q, next_tx; // Registered line level

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= uart_pkg::TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            tx_q     <= 1'b1; // Idle line is high
        end else begin
            state    <= next_state;
            tick_cnt <= next_tick_cnt;
            bit_cnt  <= next_bit_cnt;
            tx_q     <= next_tx;
        end
    end

    always_ff @(posedge i_clk) begin
        shift_reg <= next_shift;
    end

    always_comb begin
        next_state    = state;
        next_tick_cnt = tick_cnt;
        next_bit_cnt  = bit_cnt;
        next_shift    = shift_reg;
        next_tx       = tx_q;

        case (state)
            uart_pkg::TX_IDLE: begin
                if (i_tx_start) begin
                    next_state    = uart_pkg::TX_START;
                    next_tick_cnt = '0;
                    next_shift    = i_tx_data; // Latch byte on strobe
                end
            end

            uart_pkg::TX_START: begin
                if (i_tick) begin
                    if (tx_q) begin
                        // First tick after the strobe drops the line
                        next_tx = 1'b0;
                    end else if (tick_cnt == TICK_W'(`UART_OVERSAMPLE - 1)) begin
                        next_state    = uart_pkg::TX_DATA;
                        next_tick_cnt = '0;
                        next_bit_cnt  = '0;
                        next_tx       = shift_reg[0];
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end

            uart_pkg::TX_DATA: begin
                if (i_tick) begin
                    if (tick_cnt == TICK_W'(`UART_OVERSAMPLE - 1)) begin
                        next_tick_cnt = '0;
                        if (bit_cnt == BIT_W'(`UART_DATA_BITS - 1)) begin
                            next_state = uart_pkg::TX_STOP;
                            next_tx    = 1'b1; // Stop bit
                        end else begin
                            next_bit_cnt = bit_cnt + 1'b1;
                            next_shift   = {1'b0, shift_reg[`UART_DATA_BITS-1:1]};
                            next_tx      = shift_reg[1];
                        end
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end

            uart_pkg::TX_STOP: begin
                if (i_tick) begin
                    if (tick_cnt == TICK_W'(`UART_STOP_TICKS - 1)) begin
                        next_state    = uart_pkg::TX_IDLE;
                        next_tick_cnt = '0;
                    end else begin
                        next_tick_cnt = tick_cnt + 1'b1;
                    end
                end
            end
        endcase
    end

    assign o_tx      = tx_q;
    assign o_tx_busy = (state != uart_pkg::TX_IDLE); // Rises the cycle after the strobe

endmodule

`default_nettype wire

/* verilog/uart_rx_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uart_rx_fifo (
    input  logic                 i_clk,
    input  logic                 i_reset,
    input  uart_pkg::uart_byte_t i_wr,
    input  logic                 i_read,
    output uart_pkg::uart_byte_t o_head,
    output logic                 o_overflow
);

    localparam int PTR_W = `UART_FIFO_DEPTH_LOG2;
    localparam int DEPTH = 1 << PTR_W;

    logic [`UART_DATA_BITS-1:0] mem [DEPTH];
    logic [PTR_W-1:0]           wr_ptr, rd_ptr; // Wrap on their own
    logic [PTR_W:0]             count;
    logic                       full, empty;
    logic                       do_wr, do_rd;

    assign empty = (count == '0);
    assign full  = (count == (PTR_W + 1)'(DEPTH));
    assign do_wr = i_wr.valid && !full;
    assign do_rd = i_read && !empty; // Read on empty is ignored

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_overflow <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
            if (i_wr.valid && full) begin
                o_overflow <= 1'b1; // Sticky until reset
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr.data;
        end
    end

    // Show-ahead head
    always_comb begin
        o_head.valid = !empty;
        o_head.data  = mem[rd_ptr];
    end

endmodule

`default_nettype wire

/* verilog/uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uart_top (
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_rx,
    input  logic                       i_rx_read,
    input  logic                       i_tx_start,
    input  logic [`UART_DATA_BITS-1:0] i_tx_data,
    output logic [`UART_DATA_BITS-1:0] o_rx_data,
    output logic                       o_rx_valid,
    output logic                       o_frame_err,
    output logic                       o_overflow,
    output logic                       o_tx,
    output logic                       o_tx_busy
);

    logic                 tick;    // Shared by RX and TX
    uart_pkg::uart_byte_t rx_byte;
    uart_pkg::uart_byte_t fifo_head;

    baud_tick_gen #(
        .DIVISOR (`UART_TICK_DIVISOR)
    ) u_tick (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .o_tick  (tick)
    );

    uart_receiver u_rx (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_rx        (i_rx),
        .i_tick      (tick),
        .o_byte      (rx_byte),
        .o_frame_err (o_frame_err)
    );

    uart_rx_fifo u_fifo (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_wr       (rx_byte),
        .i_read     (i_rx_read),
        .o_head     (fifo_head),
        .o_overflow (o_overflow)
    );

    uart_transmitter u_tx (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_tick     (tick),
        .i_tx_start (i_tx_start),
        .i_tx_data  (i_tx_data),
        .o_tx       (o_tx),
        .o_tx_busy  (o_tx_busy)
    );

    // Unpack FIFO head
    assign o_rx_data  = fifo_head.data;
    assign o_rx_valid = fifo_head.valid;

endmodule

`default_nettype wire

/* tests/uart_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uart_top_tb;

    localparam int BIT_CLKS = `UART_OVERSAMPLE * `UART_TICK_DIVISOR; // 64 clocks per bit cell
    localparam int NUM_ROWS = 21;
    localparam int LIMIT    = NUM_ROWS * 11 * BIT_CLKS * 2;

    // Row modes
    localparam int M_LOOP   = 0;
    localparam int M_DIRECT = 1;
    localparam int M_BURST  = 2;

    // Expected outcome of a row
    localparam int E_BYTE = 0; // Byte read back at once
    localparam int E_FERR = 1; // Framing error and no byte
    localparam int E_HOLD = 2; // Byte stays in the FIFO
    localparam int E_DROP = 3; // Byte lost to a full FIFO, then drain

    logic                       i_clk;
    logic                       i_reset;
    logic                       i_rx = 1'b1;
    logic                       i_rx_read;
    logic                       i_tx_start;
    logic [`UART_DATA_BITS-1:0] i_tx_data;
    logic [`UART_DATA_BITS-1:0] o_rx_data;
    logic                       o_rx_valid;
    logic                       o_frame_err;
    logic                       o_overflow;
    logic                       o_tx;
    logic                       o_tx_busy;

    int                         row_mode [NUM_ROWS];
    logic [`UART_DATA_BITS-1:0] row_data [NUM_ROWS];
    logic                       row_stop [NUM_ROWS];
    int                         row_exp  [NUM_ROWS];
    logic [`UART_DATA_BITS-1:0] held [$]; // Bytes waiting in the FIFO

    logic loop_en;  // Serial line follows o_tx
    logic line_drv; // Level from the frame driver
    int   errors   = 0;
    int   ferr_cnt = 0;
    int   cycles   = 0;
    int   seed;

    uart_top dut (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_rx        (i_rx),
        .i_rx_read   (i_rx_read),
        .i_tx_start  (i_tx_start),
        .i_tx_data   (i_tx_data),
        .o_rx_data   (o_rx_data),
        .o_rx_valid  (o_rx_valid),
        .o_frame_err (o_frame_err),
        .o_overflow  (o_overflow),
        .o_tx        (o_tx),
        .o_tx_busy   (o_tx_busy)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        i_rx <= loop_en ? o_tx : line_drv;
    end

    always @(negedge i_clk) begin
        if (o_frame_err) begin
            ferr_cnt++;
        end
    end

    always @(posedge i_clk) begin
        cycles++;
        if (cycles >= LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic compare_byte(input string name, input logic [`UART_DATA_BITS-1:0] expected,
                                input logic [`UART_DATA_BITS-1:0] actual);
        if (expected !== actual) begin
            $display("ERR t=%0t %s expected 0x%02h got 0x%02h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic verify_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("ERR t=%0t %s expected %b got %b", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic add_row(input int idx, input int mode, input logic [`UART_DATA_BITS-1:0] value,
                           input logic stop, input int outcome);
        row_mode[idx] = mode;
        row_data[idx] = value;
        row_stop[idx] = stop;
        row_exp[idx]  = outcome;
    endtask

    function automatic string mode_name(input int mode);
        if (mode == M_LOOP) begin
            return "loopback";
        end else if (mode == M_DIRECT) begin
            return "direct";
        end
        return "burst";
    endfunction

    // Start bit, data LSB first, stop bit and a short idle
    task automatic send_frame(input logic [`UART_DATA_BITS-1:0] value, input logic stop);
        int i;
        line_drv <= 1'b0;
        repeat (BIT_CLKS) @(posedge i_clk);
        for (i = 0; i < `UART_DATA_BITS; i++) begin
            line_drv <= value[i];
            repeat (BIT_CLKS) @(posedge i_clk);
        end
        line_drv <= stop;
        if (stop) begin
            repeat (BIT_CLKS) @(posedge i_clk);
        end else begin
            // Release before the receiver would confirm a false start
            repeat (BIT_CLKS * 3 / 4) @(posedge i_clk);
            line_drv <= 1'b1;
            repeat (BIT_CLKS / 4) @(posedge i_clk);
        end
        line_drv <= 1'b1;
        repeat (16) @(posedge i_clk);
    endtask

    task automatic strobe_tx(input logic [`UART_DATA_BITS-1:0] value);
        while (o_tx_busy) @(negedge i_clk);
        @(posedge i_clk);
        i_tx_data  <= value;
        i_tx_start <= 1'b1;
        @(posedge i_clk);
        i_tx_start <= 1'b0;
        @(negedge i_clk);
        verify_flag("o_tx_busy", 1'b1, o_tx_busy);
    endtask

    task automatic wait_rx_valid();
        while (!o_rx_valid) @(negedge i_clk);
    endtask

    task automatic pop_and_check(input logic [`UART_DATA_BITS-1:0] value, input logic valid_after);
        compare_byte("o_rx_data", value, o_rx_data);
        @(posedge i_clk);
        i_rx_read <= 1'b1;
        @(posedge i_clk);
        i_rx_read <= 1'b0;
        @(negedge i_clk);
        verify_flag("o_rx_valid", valid_after, o_rx_valid);
    endtask

    // Four held bytes come out in order and the fifth is lost
    task automatic drain_fifo();
        logic [`UART_DATA_BITS-1:0] value;
        verify_flag("o_overflow", 1'b1, o_overflow);
        while (held.size() > 0) begin
            value = held.pop_front();
            verify_flag("o_rx_valid", 1'b1, o_rx_valid);
            pop_and_check(value, held.size() > 0);
        end
    endtask

    initial begin
        int r;
        int fails;
        int err_before;
        int ferr_before;
        logic [31:0] rnd;

        i_reset    = 1'b1;
        i_rx_read  = 1'b0;
        i_tx_start = 1'b0;
        i_tx_data  = '0;
        line_drv   = 1'b1;
        loop_en    = 1'b0;
        fails      = 0;
        seed       = 13;

        add_row(0,  M_LOOP,   8'h55, 1'b1, E_BYTE);
        add_row(1,  M_LOOP,   8'hA3, 1'b1, E_BYTE);
        add_row(2,  M_LOOP,   8'h00, 1'b1, E_BYTE);
        add_row(3,  M_LOOP,   8'hFF, 1'b1, E_BYTE);
        add_row(4,  M_DIRECT, 8'h3A, 1'b1, E_BYTE);
        add_row(5,  M_DIRECT, 8'h83, 1'b1, E_BYTE);
        add_row(6,  M_DIRECT, 8'h5A, 1'b0, E_FERR); // Low stop bit
        add_row(7,  M_DIRECT, 8'hC7, 1'b1, E_BYTE); // Receiver recovered
        add_row(8,  M_BURST,  8'h11, 1'b1, E_HOLD);
        add_row(9,  M_BURST,  8'h22, 1'b1, E_HOLD);
        add_row(10, M_BURST,  8'h33, 1'b1, E_HOLD);
        add_row(11, M_BURST,  8'h44, 1'b1, E_HOLD);
        add_row(12, M_BURST,  8'h55, 1'b1, E_DROP);
        for (r = 13; r < NUM_ROWS; r++) begin
            rnd = $random(seed);
            add_row(r, M_LOOP, rnd[7:0], 1'b1, E_BYTE);
        end

        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        verify_flag("o_tx", 1'b1, o_tx);
        verify_flag("o_tx_busy", 1'b0, o_tx_busy);
        verify_flag("o_rx_valid", 1'b0, o_rx_valid);
        verify_flag("o_frame_err", 1'b0, o_frame_err);
        verify_flag("o_overflow", 1'b0, o_overflow);
        if (errors != 0) begin
            fails++;
        end
        $display("Test 0 (reset): %s", (errors == 0) ? "pass" : "FAIL");

        for (r = 0; r < NUM_ROWS; r++) begin
            err_before  = errors;
            ferr_before = ferr_cnt;
            @(posedge i_clk);
            loop_en <= (row_mode[r] == M_LOOP);
            if (row_mode[r] == M_LOOP) begin
                strobe_tx(row_data[r]);
            end else begin
                send_frame(row_data[r], row_stop[r]);
            end
            @(negedge i_clk);
            case (row_exp[r])
                E_BYTE: begin
                    wait_rx_valid();
                    pop_and_check(row_data[r], 1'b0);
                end
                E_FERR: verify_flag("o_rx_valid", 1'b0, o_rx_valid);
                E_HOLD: begin
                    held.push_back(row_data[r]);
                    verify_flag("o_rx_valid", 1'b1, o_rx_valid);
                    verify_flag("o_overflow", 1'b0, o_overflow);
                end
                default: drain_fifo();
            endcase
            if (row_mode[r] == M_LOOP) begin
                while (o_tx_busy) @(negedge i_clk); // Busy falls after the stop bit
                verify_flag("o_tx", 1'b1, o_tx);
            end
            if (ferr_cnt - ferr_before != ((row_exp[r] == E_FERR) ? 1 : 0)) begin
                $display("Row %0d saw %0d framing error pulses, which is wrong",
                         r + 1, ferr_cnt - ferr_before);
                errors++;
            end
            if (errors != err_before) begin
                fails++;
            end
            $display("Test %0d (%s, 0x%02h): %s", r + 1, mode_name(row_mode[r]), row_data[r],
                     (errors == err_before) ? "pass" : "FAIL");
        end

        $display("Tests %0d, failed %0d, errors %0d", NUM_ROWS + 1, fails, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verilog
verilog/uart_pkg.sv
verilog/baud_tick_gen.sv
verilog/uart_receiver.sv
verilog/uart_transmitter.sv
verilog/uart_rx_fifo.sv
verilog/uart_top.sv
tests/uart_top_tb.sv

/* Makefile */
# Verilator build for the UART testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= uart_top_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# Pass only when the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
